// ==== vlog.f ====
+incdir+include
hdl/mem_word_pkg.sv
hdl/mem_bank_pkg.sv
hdl/cut_port_if.sv
hdl/sram_cut.sv
hdl/cut_decoder.sv
hdl/sram.sv
tests/sram_tb.sv

// ==== Makefile ====
SRCS = vlog.f include/mem_defs.svh $(wildcard hdl/*.sv) tests/sram_tb.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vsram_tb: $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module sram_tb -o Vsram_tb

run: obj_dir/Vsram_tb
	./obj_dir/Vsram_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/sram_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_tb;

  // one row of the stimulus table
  typedef struct packed {
    int                  test;
    logic                req;
    logic                we;
    mem_word_pkg::addr_t addr;
    mem_word_pkg::data_t data;
    mem_word_pkg::strb_t be;
    logic                chk;
  } entry_t;

  logic                CLK;
  logic                RSTN;
  logic                req_i;
  logic                we_i;
  mem_word_pkg::addr_t addr_i;
  mem_word_pkg::data_t wdata_i;
  mem_word_pkg::strb_t be_i;
  mem_word_pkg::data_t rdata_o;

  entry_t tbl [$];
  // shadow copy of the memory contents
  mem_word_pkg::data_t shadow [`MEM_N_WORDS];
  mem_word_pkg::data_t last_rd;
  mem_word_pkg::data_t pend_exp;
  logic                pend_chk;
  logic [31:0]         rng = 32'h4d30;
  int err_count = 0;
  int check_count = 0;
  int err_base = 0;
  int check_base = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycles = 0;
  int timeout_limit = 1000;

  sram sram_inst (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles++;
    if (cycles > timeout_limit) begin
      $display("timeout: the test table did not finish within %0d cycles", timeout_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic mem_word_pkg::data_t rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic mem_word_pkg::addr_t word_addr(input int cut, input int off);
    return mem_word_pkg::addr_t'(cut * `MEM_CUT_WORDS + off);
  endfunction

  // enabled lanes take the new byte, the rest keep the old one
  function automatic mem_word_pkg::data_t merge_bytes(input mem_word_pkg::data_t old_word,
                                                      input mem_word_pkg::data_t new_word,
                                                      input mem_word_pkg::strb_t be);
    mem_word_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < $bits(mem_word_pkg::strb_t); b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_entry(input int test, input logic req, input logic we,
                           input mem_word_pkg::addr_t addr, input mem_word_pkg::data_t data,
                           input mem_word_pkg::strb_t be, input logic chk);
    entry_t e;
    e.test = test;
    e.req = req;
    e.we = we;
    e.addr = addr;
    e.data = data;
    e.be = be;
    e.chk = chk;
    tbl.push_back(e);
  endtask

  task automatic add_write(input int test, input mem_word_pkg::addr_t addr,
                           input mem_word_pkg::strb_t be, input logic chk);
    add_entry(test, 1'b1, 1'b1, addr, rand_word(), be, chk);
  endtask

  task automatic add_read(input int test, input mem_word_pkg::addr_t addr);
    add_entry(test, 1'b1, 1'b0, addr, '0, '0, 1'b1);
  endtask

  task automatic build_table();
    int offs [3] = '{0, 512, 1023};
    mem_word_pkg::strb_t pats [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    // 1: first, middle and last word of every cut
    for (int c = 0; c < `MEM_N_CUTS; c++)
      for (int o = 0; o < 3; o++) add_write(1, word_addr(c, offs[o]), 4'hf, 1'b0);
    for (int c = 0; c < `MEM_N_CUTS; c++)
      for (int o = 0; o < 3; o++) add_read(1, word_addr(c, offs[o]));
    // 2: byte merges on top of a full word
    add_write(2, word_addr(2, 100), 4'hf, 1'b1);
    add_read(2, word_addr(2, 100));
    for (int p = 0; p < 4; p++) begin
      add_write(2, word_addr(2, 100), pats[p], 1'b1);
      add_read(2, word_addr(2, 100));
    end
    // 3: same offset in every cut
    for (int c = 0; c < `MEM_N_CUTS; c++) add_write(3, word_addr(c, 77), 4'hf, 1'b1);
    for (int c = 0; c < `MEM_N_CUTS; c++) add_read(3, word_addr(c, 77));
    // 4: back-to-back reads hopping between cuts
    add_read(4, word_addr(0, 0));
    add_read(4, word_addr(3, 1023));
    add_read(4, word_addr(1, 512));
    add_read(4, word_addr(4, 0));
    add_read(4, word_addr(2, 1023));
    add_read(4, word_addr(0, 512));
    add_read(4, word_addr(4, 1023));
    add_read(4, word_addr(1, 0));
    // 5: read data holds through idle cycles and writes
    add_read(5, word_addr(1, 512));
    add_entry(5, 1'b0, 1'b0, '0, '0, '0, 1'b1);
    add_entry(5, 1'b0, 1'b0, '0, '0, '0, 1'b1);
    add_write(5, word_addr(3, 5), 4'hf, 1'b1);
    add_write(5, word_addr(1, 5), 4'hf, 1'b1);
    add_write(5, word_addr(1, 512), 4'hf, 1'b1);
    add_entry(5, 1'b0, 1'b0, '0, '0, '0, 1'b1);
    add_read(5, word_addr(1, 512));
    // 6: read right behind a write to the same word
    for (int k = 0; k < 3; k++) begin
      add_write(6, word_addr(k * 2, 300 + k), 4'hf, 1'b1);
      add_read(6, word_addr(k * 2, 300 + k));
    end
  endtask

  task automatic check_data(input string name, input mem_word_pkg::data_t got,
                            input mem_word_pkg::data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input int test);
    int errs;
    int checks;
    errs = err_count - err_base;
    checks = check_count - check_base;
    $display("test %0d: %s, %0d checks, %0d errors", test, (errs == 0) ? "ok" : "failed",
             checks, errs);
    if (errs == 0) tests_passed++;
    else tests_failed++;
    err_base = err_count;
    check_base = check_count;
  endtask

  // drive one row and update the model with what it does at the next edge
  task automatic apply_entry(input entry_t e);
    req_i = e.req;
    we_i = e.we;
    addr_i = e.addr;
    wdata_i = e.data;
    be_i = e.be;
    if (e.req && !e.we) last_rd = shadow[e.addr];
    if (e.req && e.we) shadow[e.addr] = merge_bytes(shadow[e.addr], e.data, e.be);
    pend_chk = e.chk;
    pend_exp = last_rd;
  endtask

  initial begin
    CLK = 1'b0;
    RSTN = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    pend_chk = 1'b0;
    pend_exp = '0;
    last_rd = '0;
    build_table();
    timeout_limit = tbl.size() + 4 + 20;
    repeat (4) @(negedge CLK);
    RSTN = 1'b1;
    for (int i = 0; i < tbl.size(); i++) begin
      @(negedge CLK);
      if (pend_chk) check_data("rdata_o", rdata_o, pend_exp);
      if (i > 0 && tbl[i].test != tbl[i-1].test) report_test(tbl[i-1].test);
      apply_entry(tbl[i]);
    end
    @(negedge CLK);
    if (pend_chk) check_data("rdata_o", rdata_o, pend_exp);
    report_test(tbl[tbl.size()-1].test);
    req_i = 1'b0;
    $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/sram.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram (
  input  logic                CLK,
  input  logic                RSTN,
  // request strobe and direction
  input  logic                req_i,
  input  logic                we_i,
  // word address over all cuts
  input  mem_word_pkg::addr_t addr_i,
  // write data and byte lanes
  input  mem_word_pkg::data_t wdata_i,
  input  mem_word_pkg::strb_t be_i,
  // read data, valid one cycle after a read
  output mem_word_pkg::data_t rdata_o
);

  // one bus per cut between the decoder and that cut
  cut_port_if cut_bus [`MEM_N_CUTS] ();

  // address decode, chip enables and read mux
  cut_decoder u_decoder (
    .CLK     (CLK),
    .RSTN    (RSTN),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o),
    .cuts    (cut_bus)
  );

  // the cuts themselves, cut i holds words i*MEM_CUT_WORDS upwards
  for (genvar i = 0; i < `MEM_N_CUTS; i++) begin : gen_cut
    sram_cut u_cut (
      .CLK  (CLK),
      .port (cut_bus[i])
    );
  end

endmodule

// ==== hdl/cut_decoder.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module cut_decoder (
  input  logic                CLK,
  input  logic                RSTN,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_word_pkg::addr_t addr_i,
  input  mem_word_pkg::data_t wdata_i,
  input  mem_word_pkg::strb_t be_i,
  output mem_word_pkg::data_t rdata_o,
  cut_port_if.ctrl            cuts [`MEM_N_CUTS]
);

  mem_bank_pkg::cut_idx_t  cut_idx;
  mem_bank_pkg::cut_addr_t cut_addr;

  // one request line per cut, at most one high
  logic [`MEM_N_CUTS-1:0] cut_req;

  // read data gathered from every cut for the output mux
  mem_word_pkg::data_t cut_rdata [`MEM_N_CUTS];

  // cut that served the last accepted read
  mem_bank_pkg::cut_idx_t rd_sel_q;

  // upper bits pick the cut, lower bits the word inside it
  assign {cut_idx, cut_addr} = addr_i;

  for (genvar i = 0; i < `MEM_N_CUTS; i++) begin : gen_cut
    // chip enable for cut i
    assign cut_req[i] = req_i && (cut_idx == mem_bank_pkg::cut_idx_t'(i));

    assign cuts[i].req   = cut_req[i];
    // everything else is broadcast, only the selected cut acts on it
    assign cuts[i].we    = we_i;
    assign cuts[i].addr  = cut_addr;
    assign cuts[i].wdata = wdata_i;
    assign cuts[i].be    = be_i;

    assign cut_rdata[i] = cuts[i].rdata;
  end

  // remember which cut a read went to, writes leave the select alone
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      rd_sel_q <= '0;
    end else if (req_i && !we_i) begin
      rd_sel_q <= cut_idx;
    end
  end

  // steer the selected cut's registered data to the port
  // an out-of-range select (only after a bad address) reads as zero
  always_comb begin
    rdata_o = '0;
    for (int c = 0; c < `MEM_N_CUTS; c++) begin
      if (rd_sel_q == mem_bank_pkg::cut_idx_t'(c)) begin
        rdata_o = cut_rdata[c];
      end
    end
  end

  // upper address bits can reach past the last cut
  a_addr_in_range: assert property (
    @(posedge CLK) disable iff (!RSTN)
    req_i |-> (addr_i < `MEM_N_WORDS)
  ) else $error("cut_decoder: address %0d beyond %0d words", addr_i, `MEM_N_WORDS);

endmodule

// ==== hdl/sram_cut.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_cut (
  input logic   CLK,
  cut_port_if.mem port
);

  // storage for one cut
  mem_word_pkg::data_t mem [`MEM_CUT_WORDS];

  logic write_en;
  logic read_en;

  assign write_en = port.req && port.we;
  assign read_en  = port.req && !port.we;

  // byte-masked write, only the enabled lanes change
  always_ff @(posedge CLK) begin
    if (write_en) begin
      for (int b = 0; b < $bits(mem_word_pkg::strb_t); b++) begin
        if (port.be[b]) begin
          mem[port.addr][b*8 +: 8] <= port.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read data is registered and held until the next read of this cut
  always_ff @(posedge CLK) begin
    if (read_en) begin
      port.rdata <= mem[port.addr];
    end
  end

  // a write with no lane enabled is a wasted request, likely a requester bug
  a_write_has_lanes: assert property (
    @(posedge CLK) write_en |-> (port.be != '0)
  ) else $error("sram_cut: write with all byte enables low at addr %0d", port.addr);

endmodule

// ==== hdl/cut_port_if.sv ====
`timescale 1ns/1ps

interface cut_port_if;

  // request strobe, the cut acts on the edge where this is high
  logic req;
  // high for a write, low for a read
  logic we;
  // word address inside the cut
  mem_bank_pkg::cut_addr_t addr;
  // write data and its byte lanes
  mem_word_pkg::data_t wdata;
  mem_word_pkg::strb_t be;
  // registered read data from the cut
  mem_word_pkg::data_t rdata;

  // decoder side
  modport ctrl (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rdata
  );

  // memory cut side
  modport mem (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

// ==== hdl/mem_bank_pkg.sv ====
`include "mem_defs.svh"

package mem_bank_pkg;

  // selects one of the cuts, taken from the upper address bits
  typedef logic [$clog2(`MEM_N_CUTS)-1:0] cut_idx_t;

  // word address inside one cut, taken from the lower address bits
  typedef logic [$clog2(`MEM_CUT_WORDS)-1:0] cut_addr_t;

endpackage

// ==== hdl/mem_word_pkg.sv ====
`include "mem_defs.svh"

package mem_word_pkg;

  // word address at the port, covers all cuts
  typedef logic [$clog2(`MEM_N_WORDS)-1:0] addr_t;

  // one data word as written and read at the port
  typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

  // one enable per byte lane of a data word
  typedef logic [`MEM_DATA_WIDTH/8-1:0] strb_t;

endpackage

// ==== include/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// width of one data word in bits
`define MEM_DATA_WIDTH 32

// total number of words seen at the port
`define MEM_N_WORDS 5120

// words held by a single cut
`define MEM_CUT_WORDS 1024

// number of cuts that make up the address space
`define MEM_N_CUTS (`MEM_N_WORDS / `MEM_CUT_WORDS)

`endif
